//--- hdl/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Receiver bit timing in system clocks

`define UART_CLKS_PER_BIT 16 // One bit period

// Parity sense of the line
// 0 gives even parity and 1 gives odd parity

`define UART_PARITY_ODD 0

// Receive buffer size

`define RX_FIFO_DEPTH_LOG2 3 // 8 entries

`endif

//--- hdl/uart_pkg.sv
package uart_pkg;

    typedef logic [7:0]  uart_byte_t; // One received character
    typedef logic [15:0] rx_word_t;   // First byte in low half

    // Receiver frame position
    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_t;

    // Byte pairing position
    typedef enum logic {
        asm_wait_low,
        asm_wait_high
    } asm_state_t;

endpackage

//--- hdl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx #(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT,
    parameter int PARITY_ODD   = `UART_PARITY_ODD
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rx,
    output uart_pkg::uart_byte_t rx_byte,
    output logic                 rx_done,
    output logic                 rx_parity_error,
    output logic                 frame_error
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);

    rx_state_t        state;
    logic [CNT_W-1:0] cnt;          // Position inside current bit
    logic [2:0]       bit_idx;      // Data bit being received
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;      // For start edge detection
    logic             sample;       // Mid-bit strobe
    uart_byte_t       shift_reg;
    logic             par_bit;      // Parity bit as received
    logic             exp_par;      // Parity bit the data calls for

    // Start bit is checked half a bit in, every other bit one full bit later
    assign sample = (state == rx_start) ? (cnt == HALF_LAST) : (cnt == BIT_LAST);

    assign exp_par = (PARITY_ODD != 0) ? ~(^shift_reg) : ^shift_reg;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rx_meta     <= 1'b1; // Line idles high
            rx_sync     <= 1'b1;
            rx_prev     <= 1'b1;
            state       <= rx_idle;
            cnt         <= '0;
            bit_idx     <= '0;
            rx_done     <= 1'b0;
            frame_error <= 1'b0;
        end
        else
        begin
            rx_meta     <= rx;
            rx_sync     <= rx_meta;
            rx_prev     <= rx_sync;
            rx_done     <= 1'b0;
            frame_error <= 1'b0;

            if (state == rx_idle || sample)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            case (state)
                rx_idle:
                begin
                    if (rx_prev && !rx_sync) // Falling edge
                        state <= rx_start;
                end
                rx_start:
                begin
                    if (sample)
                    begin
                        if (rx_sync)
                            state <= rx_idle; // Glitch, not a start bit
                        else
                        begin
                            state   <= rx_data;
                            bit_idx <= '0;
                        end
                    end
                end
                rx_data:
                begin
                    if (sample)
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= rx_parity;
                    end
                end
                rx_parity:
                begin
                    if (sample)
                        state <= rx_stop;
                end
                rx_stop:
                begin
                    if (sample)
                    begin
                        rx_done     <= rx_sync;  // Good stop bit
                        frame_error <= !rx_sync; // Byte is dropped
                        state       <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (sample && state == rx_data)
            shift_reg <= {rx_sync, shift_reg[7:1]}; // LSB arrives first
        if (sample && state == rx_parity)
            par_bit <= rx_sync;
        if (sample && state == rx_stop)
        begin
            rx_byte         <= shift_reg;
            rx_parity_error <= par_bit ^ exp_par;
        end
    end

endmodule

//--- hdl/rx_fifo.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module rx_fifo #(
    parameter int DEPTH_LOG2 = `RX_FIFO_DEPTH_LOG2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr,
    input  uart_pkg::uart_byte_t wr_byte,
    input  logic                 wr_parity_error,
    input  logic                 rd,
    output uart_pkg::uart_byte_t rd_byte,
    output logic                 rd_parity_error,
    output logic                 empty,
    output logic                 overflow
);
    import uart_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;

    uart_byte_t          mem_byte [DEPTH];
    logic                mem_par  [DEPTH];
    logic [DEPTH_LOG2:0] wr_ptr;  // Extra bit tells full from empty
    logic [DEPTH_LOG2:0] rd_ptr;
    logic                full;
    logic                rd_en;
    logic                wr_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                   (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

    assign rd_en = rd && !empty;
    assign wr_en = wr && (!full || rd_en); // Read frees the slot when full

    // Show-ahead head entry
    assign rd_byte         = mem_byte[rd_ptr[DEPTH_LOG2-1:0]];
    assign rd_parity_error = mem_par[rd_ptr[DEPTH_LOG2-1:0]];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (wr && !wr_en)
                overflow <= 1'b1; // Sticky until reset
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem_byte[wr_ptr[DEPTH_LOG2-1:0]] <= wr_byte;
            mem_par[wr_ptr[DEPTH_LOG2-1:0]]  <= wr_parity_error;
        end
    end

endmodule

//--- hdl/word_assembler.sv
`timescale 1ns/1ps

module word_assembler (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pause,
    input  uart_pkg::uart_byte_t fifo_byte,
    input  logic                 fifo_parity_error,
    input  logic                 fifo_empty,
    output logic                 fifo_rd,
    output uart_pkg::rx_word_t   word_out,
    output logic                 word_parity_error,
    output logic                 word_valid
);
    import uart_pkg::*;

    asm_state_t state;
    uart_byte_t low_byte;  // First byte of the pair
    logic       low_par;

    // One byte per cycle whenever the head is valid
    assign fifo_rd = !fifo_empty && !pause;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= asm_wait_low;
            word_valid <= 1'b0;
        end
        else
        begin
            word_valid <= 1'b0;
            if (fifo_rd)
            begin
                case (state)
                    asm_wait_low:  state <= asm_wait_high;
                    asm_wait_high:
                    begin
                        state      <= asm_wait_low;
                        word_valid <= 1'b1; // Pair complete
                    end
                    default:       state <= asm_wait_low;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fifo_rd && state == asm_wait_low)
        begin
            low_byte <= fifo_byte;
            low_par  <= fifo_parity_error;
        end
        if (fifo_rd && state == asm_wait_high)
        begin
            word_out          <= {fifo_byte, low_byte};
            word_parity_error <= low_par | fifo_parity_error; // Either byte bad
        end
    end

endmodule

//--- hdl/uart_rx_subsystem.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx_subsystem (
    input  logic               clk,
    input  logic               reset,
    input  logic               rx,
    input  logic               pause,
    output uart_pkg::rx_word_t word_out,
    output logic               word_valid,
    output logic               word_parity_error,
    output logic               frame_error,
    output logic               fifo_overflow
);
    import uart_pkg::*;

    uart_byte_t rx_byte;
    logic       rx_done;
    logic       rx_parity_error;
    uart_byte_t fifo_byte;
    logic       fifo_parity_error;
    logic       fifo_empty;
    logic       fifo_rd;

    uart_rx #(
        .CLKS_PER_BIT (`UART_CLKS_PER_BIT),
        .PARITY_ODD   (`UART_PARITY_ODD)
    ) u_rx (
        .clk             (clk),
        .reset           (reset),
        .rx              (rx),
        .rx_byte         (rx_byte),
        .rx_done         (rx_done),
        .rx_parity_error (rx_parity_error),
        .frame_error     (frame_error)
    );

    rx_fifo #(
        .DEPTH_LOG2 (`RX_FIFO_DEPTH_LOG2)
    ) u_fifo (
        .clk             (clk),
        .reset           (reset),
        .wr              (rx_done),
        .wr_byte         (rx_byte),
        .wr_parity_error (rx_parity_error),
        .rd              (fifo_rd),
        .rd_byte         (fifo_byte),
        .rd_parity_error (fifo_parity_error),
        .empty           (fifo_empty),
        .overflow        (fifo_overflow)
    );

    word_assembler u_asm (
        .clk               (clk),
        .reset             (reset),
        .pause             (pause),
        .fifo_byte         (fifo_byte),
        .fifo_parity_error (fifo_parity_error),
        .fifo_empty        (fifo_empty),
        .fifo_rd           (fifo_rd),
        .word_out          (word_out),
        .word_parity_error (word_parity_error),
        .word_valid        (word_valid)
    );

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD_NS = 40.0
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk; // Free running
    end

endmodule

//--- tests/uart_rx_subsystem_tb.sv
`timescale 1ns/1ps
`include "uart_macros.svh"

module uart_rx_subsystem_tb;
    import uart_pkg::*;

    localparam int CPB        = `UART_CLKS_PER_BIT;
    localparam int FIFO_DEPTH = 1 << `RX_FIFO_DEPTH_LOG2;
    localparam int WAIT_LIMIT = 20 * CPB; // Cycles allowed for the words to drain

    logic       clk;
    logic       reset;
    logic       rx;
    logic       pause;
    rx_word_t   word_out;
    logic       word_valid;
    logic       word_parity_error;
    logic       frame_error;
    logic       fifo_overflow;

    uart_byte_t tbl_byte[$];     // Stimulus table
    logic       tbl_bad_par[$];
    logic       tbl_bad_stop[$];
    logic       tbl_pause[$];
    rx_word_t   exp_word[$];
    logic       exp_perr[$];
    int         exp_frame_errors;
    rx_word_t   got_word[$];
    logic       got_perr[$];
    int         frame_error_count = 0;
    int unsigned seed_init;

    clock_gen #(.PERIOD_NS(40.0)) u_clk (.clk(clk));

    uart_rx_subsystem dut (
        .clk               (clk),
        .reset             (reset),
        .rx                (rx),
        .pause             (pause),
        .word_out          (word_out),
        .word_valid        (word_valid),
        .word_parity_error (word_parity_error),
        .frame_error       (frame_error),
        .fifo_overflow     (fifo_overflow)
    );

    // Word and frame error monitor
    always @(posedge clk)
    begin
        if (word_valid)
        begin
            got_word.push_back(word_out);
            got_perr.push_back(word_parity_error);
        end
        if (frame_error)
            frame_error_count++;
    end

    task automatic check_value(input string name, input logic [31:0] act_val,
                               input logic [31:0] exp_val);
        if (act_val !== exp_val)
        begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, act_val, exp_val);
            $display("TESTS FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("TESTS FAILED");
        $fatal(1, "Timeout");
    endtask

    task automatic add_entry(input uart_byte_t b, input logic bad_par, input logic bad_stop,
                             input logic p);
        tbl_byte.push_back(b);
        tbl_bad_par.push_back(bad_par);
        tbl_bad_stop.push_back(bad_stop);
        tbl_pause.push_back(p);
    endtask

    // Called right after a rising edge, returns on one
    task automatic drive_bit(input logic b);
        rx <= b;
        repeat (CPB) @(posedge clk);
    endtask

    task automatic send_frame(input uart_byte_t b, input logic bad_par, input logic bad_stop);
        logic par;
        int   gap;
        par = (^b) ^ (`UART_PARITY_ODD != 0) ^ bad_par; // Odd sense flips the bit
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(b[i]); // LSB first
        drive_bit(par);
        drive_bit(!bad_stop);
        gap = 1 + ($urandom % 3);
        repeat (gap) drive_bit(1'b1);
    endtask

    // Pairing rule plus FIFO capacity while paused
    function automatic void build_expected();
        int         held;
        logic       have_first;
        uart_byte_t first_byte;
        logic       first_perr;
        held = 0;
        have_first = 1'b0;
        exp_frame_errors = 0;
        for (int i = 0; i < tbl_byte.size(); i++)
        begin
            if (tbl_bad_stop[i])
                exp_frame_errors++;
            else if (tbl_pause[i] && held >= FIFO_DEPTH)
                held = held; // Lost to overflow
            else
            begin
                held = tbl_pause[i] ? held + 1 : 0;
                if (!have_first)
                begin
                    first_byte = tbl_byte[i];
                    first_perr = tbl_bad_par[i];
                    have_first = 1'b1;
                end
                else
                begin
                    exp_word.push_back({tbl_byte[i], first_byte});
                    exp_perr.push_back(first_perr | tbl_bad_par[i]);
                    have_first = 1'b0;
                end
            end
        end
    endfunction

    task automatic wait_for_words(input int count);
        int cycles;
        cycles = 0;
        while (got_word.size() < count)
        begin
            if (cycles >= WAIT_LIMIT)
                report_timeout("the assembled words");
            @(posedge clk);
            cycles++;
        end
    endtask

    initial
    begin
        reset = 1'b1;
        rx    = 1'b1;
        pause = 1'b0;
        seed_init = $urandom(32'hd1c8_02ea);

        add_entry(8'h00, 1'b0, 1'b0, 1'b0);
        add_entry(8'hff, 1'b0, 1'b0, 1'b0);
        add_entry(8'ha5, 1'b0, 1'b0, 1'b0);
        add_entry(8'h3c, 1'b0, 1'b0, 1'b0);
        add_entry(8'h12, 1'b1, 1'b0, 1'b0); // Bad parity in low byte
        add_entry(8'h34, 1'b0, 1'b0, 1'b0);
        add_entry(8'h56, 1'b0, 1'b0, 1'b0);
        add_entry(8'h78, 1'b1, 1'b0, 1'b0); // Bad parity in high byte
        add_entry(8'h81, 1'b0, 1'b0, 1'b0);
        add_entry(8'h9a, 1'b0, 1'b1, 1'b0); // Framing error, dropped
        add_entry(8'h7e, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < FIFO_DEPTH + 2; i++)
            add_entry(8'h20 + i, 1'b0, 1'b0, 1'b1); // Overruns the FIFO
        build_expected();

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Quiet outputs after reset
        repeat (2 * CPB)
        begin
            @(posedge clk);
            check_value("word_valid", word_valid, 0);
            check_value("frame_error", frame_error, 0);
            check_value("fifo_overflow", fifo_overflow, 0);
        end

        for (int i = 0; i < tbl_byte.size(); i++)
        begin
            pause <= tbl_pause[i];
            if (!tbl_pause[i])
                check_value("fifo_overflow", fifo_overflow, 0);
            send_frame(tbl_byte[i], tbl_bad_par[i], tbl_bad_stop[i]);
            if (i == 0)
            begin
                // Low pulse shorter than half a bit while the first byte waits for a partner
                rx <= 1'b0;
                repeat (CPB / 4) @(posedge clk);
                rx <= 1'b1;
                repeat (12 * CPB) @(posedge clk); // Longer than a whole frame
                check_value("frame_error count", frame_error_count, 0);
                check_value("word count", got_word.size(), 0);
            end
        end
        check_value("fifo_overflow", fifo_overflow, 1);

        pause <= 1'b0;
        wait_for_words(exp_word.size());
        repeat (4 * CPB) @(posedge clk); // Room for any extra word
        check_value("word count", got_word.size(), exp_word.size());
        for (int i = 0; i < exp_word.size(); i++)
        begin
            check_value($sformatf("word_out[%0d]", i), got_word[i], exp_word[i]);
            check_value($sformatf("word_parity_error[%0d]", i), got_perr[i], exp_perr[i]);
        end
        check_value("frame_error count", frame_error_count, exp_frame_errors);
        check_value("fifo_overflow", fifo_overflow, 1);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- src.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/rx_fifo.sv
hdl/word_assembler.sv
hdl/uart_rx_subsystem.sv
tests/clock_gen.sv
tests/uart_rx_subsystem_tb.sv

//--- Bender.yml
package:
  name: uart_rx_subsystem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/uart_pkg.sv
      - hdl/uart_rx.sv
      - hdl/rx_fifo.sv
      - hdl/word_assembler.sv
      - hdl/uart_rx_subsystem.sv
      - target: test
        files:
          - tests/clock_gen.sv
          - tests/uart_rx_subsystem_tb.sv
